// File: source/pw_pkg.sv
`default_nettype none

package pw_pkg;

    // ============================================================
    // Modulus and coefficient layout
    // ============================================================

    localparam int unsigned COEF_W = 23;
    localparam logic [COEF_W-1:0] MLDSA_Q = 23'd8380417;

    // One memory slot carries a coefficient plus a zero top bit
    localparam int unsigned SLOT_W         = 24;
    localparam int unsigned COEFS_PER_WORD = 4;
    localparam int unsigned WORD_W         = COEFS_PER_WORD * SLOT_W;

    localparam int unsigned POLY_WORDS = 64;
    localparam int unsigned WORD_CNT_W = $clog2(POLY_WORDS + 1);
    localparam int unsigned ADDR_W     = 15;

    // ============================================================
    // Operand b flow control and pipeline depth
    // ============================================================

    // FIFO depth equals the credits the b source starts with
    localparam int unsigned B_FIFO_DEPTH = 4;
    localparam int unsigned B_PTR_W      = $clog2(B_FIFO_DEPTH);

    // Read request to write of the same word
    localparam int unsigned PIPE_LAT = 3;

    typedef logic [COEF_W-1:0]     coef_t;
    typedef logic [2*COEF_W-1:0]   wide_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_CNT_W-1:0] word_cnt_t;

    typedef enum logic [1:0] {
        PW_MUL = 2'd0,
        PW_ADD = 2'd1,
        PW_SUB = 2'd2
    } pw_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        ST_DRAIN = 2'd2
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: source/pw_ctrl_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module pw_ctrl_fsm (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 start_i,
    input  wire pw_pkg::pw_op_e op_i,
    input  wire                 accumulate_i,
    input  wire                 last_issued_i,
    input  wire                 pipe_empty_i,
    output logic                load_o,
    output logic                run_o,
    output pw_pkg::pw_op_e      op_o,
    output logic                c_read_o,
    output logic                busy_o,
    output logic                done_o
);
    import pw_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        accept;

    // Starts are only taken while idle
    assign accept = start_i && (state == ST_IDLE);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                if (last_issued_i) begin
                    state_next = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // Words in flight still have to be written
                if (pipe_empty_i) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= ST_IDLE;
            op_o     <= PW_MUL;
            c_read_o <= 1'b0;
        end else begin
            state <= state_next;
            if (accept) begin
                op_o     <= op_i;
                // Accumulate only has a meaning for multiply
                c_read_o <= accumulate_i && (op_i == PW_MUL);
            end
        end
    end

    assign load_o = accept;
    assign run_o  = (state == ST_RUN);
    assign done_o = (state == ST_DRAIN) && pipe_empty_i;
    assign busy_o = (state != ST_IDLE) && !done_o;

endmodule

`default_nettype wire

// File: source/pw_word_counter.sv
`timescale 1ns/10ps
`default_nettype none

module pw_word_counter (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                load_i,
    input  wire                run_i,
    input  wire                b_avail_i,
    input  wire pw_pkg::addr_t a_base_i,
    input  wire pw_pkg::addr_t c_base_i,
    output logic               issue_o,
    output pw_pkg::addr_t      a_rd_addr_o,
    output pw_pkg::addr_t      c_rd_addr_o,
    output logic               last_issued_o,
    output logic               wr_en_o,
    output pw_pkg::addr_t      wr_addr_o,
    output logic               pipe_empty_o
);
    import pw_pkg::*;

    addr_t               a_base_q;
    addr_t               c_base_q;
    word_cnt_t           count;
    logic [PIPE_LAT-1:0] issue_sr;
    addr_t               addr_sr [PIPE_LAT];

    // One word per cycle while running and a b word is waiting
    assign issue_o       = run_i && b_avail_i && (count != word_cnt_t'(POLY_WORDS));
    assign last_issued_o = issue_o && (count == word_cnt_t'(POLY_WORDS - 1));

    assign a_rd_addr_o = a_base_q + addr_t'(count);
    assign c_rd_addr_o = c_base_q + addr_t'(count);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_base_q <= '0;
            c_base_q <= '0;
            count    <= '0;
            issue_sr <= '0;
        end else begin
            if (load_i) begin
                a_base_q <= a_base_i;
                c_base_q <= c_base_i;
                count    <= '0;
            end else if (issue_o) begin
                count <= count + 1'b1;
            end
            issue_sr <= {issue_sr[PIPE_LAT-2:0], issue_o};
        end
    end

    // Write address follows its issue flag down the timer
    always_ff @(posedge clk) begin
        addr_sr[0] <= c_rd_addr_o;
        for (int i = 1; i < PIPE_LAT; i++) begin
            addr_sr[i] <= addr_sr[i-1];
        end
    end

    assign wr_en_o      = issue_sr[PIPE_LAT-1];
    assign wr_addr_o    = addr_sr[PIPE_LAT-1];
    assign pipe_empty_o = (issue_sr == '0);

endmodule

`default_nettype wire

// File: source/pw_b_credit_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module pw_b_credit_fifo (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                push_i,
    input  wire pw_pkg::word_t push_data_i,
    input  wire                pop_i,
    output logic               b_avail_o,
    output pw_pkg::word_t      pop_data_o,
    output logic               credit_o
);
    import pw_pkg::*;

    word_t              mem [B_FIFO_DEPTH];
    logic [B_PTR_W-1:0] wr_ptr;
    logic [B_PTR_W-1:0] rd_ptr;
    logic [B_PTR_W:0]   count;
    logic               do_pop;

    assign b_avail_o  = (count != '0);
    assign do_pop     = pop_i && b_avail_o;
    assign pop_data_o = mem[rd_ptr];

    // Each word taken hands one credit back to the source
    assign credit_o = do_pop;

    // ============================================================
    // Pointers and fill level
    // ============================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Credits keep the source from pushing into a full buffer
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: source/pw_mod_lane.sv
`timescale 1ns/10ps
`default_nettype none

module pw_mod_lane (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire pw_pkg::pw_op_e op_i,
    input  wire                 c_read_i,
    input  wire pw_pkg::coef_t  a_i,
    input  wire pw_pkg::coef_t  b_i,
    input  wire pw_pkg::coef_t  c_i,
    output pw_pkg::coef_t       r_o
);
    import pw_pkg::*;

    wide_t             s1_next;
    wide_t             s1_val;
    coef_t             s1_c;
    coef_t             red;
    logic [COEF_W:0]   acc;

    // Stage one forms the raw product, sum or difference lifted by q
    always_comb begin
        case (op_i)
            PW_MUL:  s1_next = wide_t'(a_i) * wide_t'(b_i);
            PW_ADD:  s1_next = wide_t'(a_i) + wide_t'(b_i);
            PW_SUB:  s1_next = wide_t'(a_i) + wide_t'(MLDSA_Q) - wide_t'(b_i);
            default: s1_next = '0;
        endcase
    end

    // Stage two reduces and then folds in the old c word
    always_comb begin
        red = coef_t'(s1_val % wide_t'(MLDSA_Q));
        acc = {1'b0, red};
        if (c_read_i) begin
            acc = acc + {1'b0, s1_c};
        end
        // Both terms are below q so one subtract is enough
        if (acc >= {1'b0, MLDSA_Q}) begin
            acc = acc - {1'b0, MLDSA_Q};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_val <= '0;
            s1_c   <= '0;
            r_o    <= '0;
        end else begin
            s1_val <= s1_next;
            s1_c   <= c_i;
            r_o    <= acc[COEF_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: source/pw_top.sv
`timescale 1ns/10ps
`default_nettype none

module pw_top (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 start_i,
    input  wire pw_pkg::pw_op_e op_i,
    input  wire                 accumulate_i,
    input  wire pw_pkg::addr_t  a_base_i,
    input  wire pw_pkg::addr_t  c_base_i,
    input  wire                 b_valid_i,
    input  wire pw_pkg::word_t  b_data_i,
    input  wire pw_pkg::word_t  a_rd_data_i,
    input  wire pw_pkg::word_t  c_rd_data_i,
    output logic                b_credit_o,
    output logic                a_rd_en_o,
    output pw_pkg::addr_t       a_rd_addr_o,
    output logic                c_rd_en_o,
    output pw_pkg::addr_t       c_rd_addr_o,
    output logic                c_wr_en_o,
    output pw_pkg::addr_t       c_wr_addr_o,
    output pw_pkg::word_t       c_wr_data_o,
    output logic                busy_o,
    output logic                done_o
);
    import pw_pkg::*;

    logic   load;
    logic   run;
    pw_op_e op;
    logic   c_read;
    logic   issue;
    logic   last_issued;
    logic   pipe_empty;
    logic   b_avail;
    word_t  b_pop_data;
    word_t  b_word_q;
    coef_t  lane_r [COEFS_PER_WORD];

    pw_ctrl_fsm u_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .start_i       (start_i),
        .op_i          (op_i),
        .accumulate_i  (accumulate_i),
        .last_issued_i (last_issued),
        .pipe_empty_i  (pipe_empty),
        .load_o        (load),
        .run_o         (run),
        .op_o          (op),
        .c_read_o      (c_read),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    pw_word_counter u_counter (
        .clk           (clk),
        .reset_n       (reset_n),
        .load_i        (load),
        .run_i         (run),
        .b_avail_i     (b_avail),
        .a_base_i      (a_base_i),
        .c_base_i      (c_base_i),
        .issue_o       (issue),
        .a_rd_addr_o   (a_rd_addr_o),
        .c_rd_addr_o   (c_rd_addr_o),
        .last_issued_o (last_issued),
        .wr_en_o       (c_wr_en_o),
        .wr_addr_o     (c_wr_addr_o),
        .pipe_empty_o  (pipe_empty)
    );

    pw_b_credit_fifo u_b_fifo (
        .clk         (clk),
        .reset_n     (reset_n),
        .push_i      (b_valid_i),
        .push_data_i (b_data_i),
        .pop_i       (issue),
        .b_avail_o   (b_avail),
        .pop_data_o  (b_pop_data),
        .credit_o    (b_credit_o)
    );

    assign a_rd_en_o = issue;
    assign c_rd_en_o = issue && c_read;

    // Popped b word waits one cycle for the memory read data
    always_ff @(posedge clk) begin
        b_word_q <= b_pop_data;
    end

    // ============================================================
    // Arithmetic lanes, one per coefficient slot
    // ============================================================

    for (genvar i = 0; i < COEFS_PER_WORD; i++) begin : g_lane
        pw_mod_lane u_lane (
            .clk      (clk),
            .reset_n  (reset_n),
            .op_i     (op),
            .c_read_i (c_read),
            .a_i      (a_rd_data_i[i*SLOT_W +: COEF_W]),
            .b_i      (b_word_q[i*SLOT_W +: COEF_W]),
            .c_i      (c_rd_data_i[i*SLOT_W +: COEF_W]),
            .r_o      (lane_r[i])
        );
    end

    // Top bit of every slot stays zero
    always_comb begin
        c_wr_data_o = '0;
        for (int i = 0; i < COEFS_PER_WORD; i++) begin
            c_wr_data_o[i*SLOT_W +: COEF_W] = lane_r[i];
        end
    end

endmodule

`default_nettype wire

// File: tb/pw_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module pw_asserts (
    input wire clk,
    input wire reset_n,
    input wire b_valid_i,
    input wire issue_i,
    input wire wr_en_i,
    input wire busy_i,
    input wire done_i
);
    import pw_pkg::*;

    int fill;

    // FIFO occupancy from pushes and actual pops
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fill <= 0;
        end else if (b_valid_i && !issue_i) begin
            fill <= fill + 1;
        end else if (!b_valid_i && issue_i) begin
            fill <= fill - 1;
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        !(b_valid_i && (fill >= int'(B_FIFO_DEPTH))))
        else $error("b word pushed while the FIFO was full");

    write_follows_issue: assert property (@(posedge clk) disable iff (!reset_n)
        wr_en_i == $past(issue_i, PIPE_LAT))
        else $error("write enable does not match the issue flag of PIPE_LAT cycles ago");

    done_single_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else $error("done stayed high for more than one cycle");

    idle_in_reset: assert property (@(posedge clk)
        !reset_n |-> (!busy_i && !wr_en_i && !done_i))
        else $error("busy, done or write enable high during reset");

endmodule

bind pw_top pw_asserts u_asserts (
    .clk        (clk),
    .reset_n    (reset_n),
    .b_valid_i  (b_valid_i),
    .issue_i    (issue),
    .wr_en_i    (c_wr_en_o),
    .busy_i     (busy_o),
    .done_i     (done_o)
);

`default_nettype wire

// File: tb/pw_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pw_tb;
    import pw_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 7374;
    localparam int NUM_ROWS     = 6;
    localparam int MAX_GAP      = 5;
    localparam int MARGIN_NS    = 2000;
    localparam int WATCHDOG_NS  =
        NUM_ROWS * int'(POLY_WORDS) * (MAX_GAP + 2) * CLK_PERIOD + MARGIN_NS;
    localparam int MEM_WORDS    = 1 << ADDR_W;
    localparam int DUP_DELAY    = 10;
    localparam int DUP_C_BASE   = 4096;
    localparam int MAX_SHOWN    = 16;
    localparam int unsigned Q_MAX = 32'(MLDSA_Q) - 1;

    typedef struct {
        string  name;
        pw_op_e op;
        bit     acc;
        int     a_base;
        int     c_base;
        int     max_gap;
        bit     edge_vals;
        bit     dup_start;
    } row_t;

    logic   clk = 1'b0;
    logic   reset_n;
    logic   start_i;
    pw_op_e op_i;
    logic   accumulate_i;
    addr_t  a_base_i;
    addr_t  c_base_i;
    logic   b_valid_i;
    word_t  b_data_i;
    word_t  a_rd_data_i = '0;
    word_t  c_rd_data_i = '0;
    logic   b_credit_o;
    logic   a_rd_en_o;
    addr_t  a_rd_addr_o;
    logic   c_rd_en_o;
    addr_t  c_rd_addr_o;
    logic   c_wr_en_o;
    addr_t  c_wr_addr_o;
    word_t  c_wr_data_o;
    logic   busy_o;
    logic   done_o;

    word_t a_mem  [MEM_WORDS];
    word_t c_mem  [MEM_WORDS];
    word_t c_init [MEM_WORDS];
    word_t c_snap [MEM_WORDS];
    word_t b_words [POLY_WORDS];
    row_t  rows [NUM_ROWS];

    int wr_count = 0;
    int done_count = 0;
    int c_rd_count = 0;
    int credits_returned = 0;
    int words_sent = 0;
    int value_errors = 0;
    int ctrl_errors = 0;

    pw_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ============================================================
    // Memory models and event counters
    // ============================================================

    // One-cycle read latency and c memory loaded while in reset
    always @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                c_mem[i] <= c_init[i];
            end
        end else begin
            if (a_rd_en_o) begin
                a_rd_data_i <= a_mem[a_rd_addr_o];
            end
            if (c_rd_en_o) begin
                c_rd_data_i <= c_mem[c_rd_addr_o];
            end
            if (c_wr_en_o) begin
                c_mem[c_wr_addr_o] <= c_wr_data_o;
            end
        end
    end

    always @(posedge clk) begin
        if (c_wr_en_o) begin
            wr_count <= wr_count + 1;
        end
        if (done_o) begin
            done_count <= done_count + 1;
        end
        if (c_rd_en_o) begin
            c_rd_count <= c_rd_count + 1;
        end
        if (b_credit_o) begin
            credits_returned <= credits_returned + 1;
        end
    end

    // ============================================================
    // Stimulus table and reference model
    // ============================================================

    task automatic build_table();
        rows[0] = '{"mul_plain",     PW_MUL, 1'b0, 0,   1024, 0, 1'b0, 1'b0};
        rows[1] = '{"mul_acc",       PW_MUL, 1'b1, 64,  1088, 0, 1'b0, 1'b0};
        rows[2] = '{"add_wrap",      PW_ADD, 1'b1, 128, 1152, 0, 1'b1, 1'b0};
        rows[3] = '{"sub_wrap",      PW_SUB, 1'b0, 192, 1216, 0, 1'b1, 1'b0};
        rows[4] = '{"mul_acc_stall", PW_MUL, 1'b1, 256, 1280, 5, 1'b0, 1'b0};
        rows[5] = '{"add_stall_dup", PW_ADD, 1'b0, 320, 1344, 3, 1'b0, 1'b1};
    endtask

    function automatic word_t random_word();
        word_t w;
        w = '0;
        for (int i = 0; i < COEFS_PER_WORD; i++) begin
            w[i*SLOT_W +: COEF_W] = coef_t'($urandom_range(Q_MAX, 0));
        end
        return w;
    endfunction

    // Slots cycle through all pairs of 0 and q-1 for a and b
    function automatic word_t edge_word(int k, bit is_b);
        word_t w;
        int    sel;
        w = '0;
        for (int i = 0; i < COEFS_PER_WORD; i++) begin
            sel = (i + k) % 4;
            if (is_b ? sel[1] : sel[0]) begin
                w[i*SLOT_W +: COEF_W] = MLDSA_Q - 1'b1;
            end
        end
        return w;
    endfunction

    function automatic coef_t ref_coef(pw_op_e op, bit acc, coef_t a, coef_t b, coef_t c);
        longint unsigned q;
        longint unsigned ua;
        longint unsigned ub;
        longint unsigned uc;
        longint unsigned r;
        longint          diff;
        q  = MLDSA_Q;
        ua = a;
        ub = b;
        uc = c;
        case (op)
            PW_MUL: begin
                r = (ua * ub) % q;
                if (acc) begin
                    r = (r + uc) % q;
                end
            end
            PW_ADD:  r = (ua + ub) % q;
            PW_SUB: begin
                // Negative differences wrap to the top of the field
                diff = longint'(ua) - longint'(ub);
                if (diff < 0) begin
                    diff = diff + longint'(q);
                end
                r = diff;
            end
            default: r = 0;
        endcase
        return coef_t'(r);
    endfunction

    function automatic word_t expected_word(pw_op_e op, bit acc, word_t a, word_t b, word_t c);
        word_t w;
        w = '0;
        for (int i = 0; i < COEFS_PER_WORD; i++) begin
            w[i*SLOT_W +: COEF_W] = ref_coef(op, acc, a[i*SLOT_W +: COEF_W],
                                             b[i*SLOT_W +: COEF_W], c[i*SLOT_W +: COEF_W]);
        end
        return w;
    endfunction

    // ============================================================
    // Drivers and checks
    // ============================================================

    // b source spends one credit per word and waits a random gap
    task automatic send_b_stream(input int max_gap);
        int k;
        int gap_left;
        k = 0;
        gap_left = 0;
        while (k < int'(POLY_WORDS)) begin
            @(posedge clk);
            #1;
            b_valid_i = 1'b0;
            if (gap_left > 0) begin
                gap_left--;
            end else if (int'(B_FIFO_DEPTH) + credits_returned - words_sent > 0) begin
                b_valid_i = 1'b1;
                b_data_i  = b_words[k];
                words_sent++;
                k++;
                gap_left = int'($urandom_range(max_gap, 0));
            end
        end
        @(posedge clk);
        #1;
        b_valid_i = 1'b0;
    endtask

    task automatic drive_start(input row_t row);
        @(posedge clk);
        #1;
        start_i      = 1'b1;
        op_i         = row.op;
        accumulate_i = row.acc;
        a_base_i     = addr_t'(row.a_base);
        c_base_i     = addr_t'(row.c_base);
        @(posedge clk);
        #1;
        start_i = 1'b0;
        if (row.dup_start) begin
            repeat (DUP_DELAY) @(posedge clk);
            #1;
            if (!busy_o) begin
                ctrl_errors++;
                $display("%s: busy was low in the middle of a run", row.name);
            end
            // Ignored start that would write outside this run's c range
            start_i      = 1'b1;
            op_i         = PW_MUL;
            accumulate_i = 1'b1;
            c_base_i     = addr_t'(DUP_C_BASE);
            @(posedge clk);
            #1;
            start_i = 1'b0;
        end
        @(negedge clk);
        while (!done_o) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_count(input string name, input string what,
                                 input int exp_val, input int act_val);
        if (exp_val != act_val) begin
            ctrl_errors++;
            $display("FAIL %s %s: expected %0d, actual %0d", name, what, exp_val, act_val);
        end
    endtask

    task automatic run_row(input row_t row);
        int    done_before;
        int    wr_before;
        int    rd_before;
        int    cred_before;
        int    idx;
        int    shown;
        word_t exp_word;
        for (int k = 0; k < int'(POLY_WORDS); k++) begin
            if (row.edge_vals) begin
                a_mem[row.a_base + k] = edge_word(k, 1'b0);
                b_words[k] = edge_word(k, 1'b1);
            end else begin
                b_words[k] = random_word();
            end
        end
        c_snap      = c_mem;
        done_before = done_count;
        wr_before   = wr_count;
        rd_before   = c_rd_count;
        cred_before = credits_returned;
        fork
            drive_start(row);
            send_b_stream(row.max_gap);
        join
        @(posedge clk);
        #1;
        compare_count(row.name, "done pulses", 1, done_count - done_before);
        compare_count(row.name, "writes", int'(POLY_WORDS), wr_count - wr_before);
        compare_count(row.name, "c reads", (row.op == PW_MUL && row.acc) ? int'(POLY_WORDS) : 0,
                      c_rd_count - rd_before);
        compare_count(row.name, "credits returned", int'(POLY_WORDS),
                      credits_returned - cred_before);
        compare_count(row.name, "credit balance", int'(B_FIFO_DEPTH),
                      int'(B_FIFO_DEPTH) + credits_returned - words_sent);
        // Words outside the run's c range must keep their old value
        shown = 0;
        for (int addr = 0; addr < MEM_WORDS; addr++) begin
            idx = addr - row.c_base;
            if (idx >= 0 && idx < int'(POLY_WORDS)) begin
                exp_word = expected_word(row.op, row.acc, a_mem[row.a_base + idx],
                                         b_words[idx], c_snap[addr]);
            end else begin
                exp_word = c_snap[addr];
            end
            if (c_mem[addr] !== exp_word) begin
                value_errors++;
                if (shown < MAX_SHOWN) begin
                    $display("FAIL %s word %0d: expected %h, actual %h",
                             row.name, addr, exp_word, c_mem[addr]);
                    shown++;
                end
            end
        end
    endtask

    // ============================================================
    // Main sequence and watchdog
    // ============================================================

    initial begin
        void'($urandom(SEED));
        reset_n      = 1'b0;
        start_i      = 1'b0;
        op_i         = PW_MUL;
        accumulate_i = 1'b0;
        a_base_i     = '0;
        c_base_i     = '0;
        b_valid_i    = 1'b0;
        b_data_i     = '0;
        build_table();
        for (int i = 0; i < MEM_WORDS; i++) begin
            a_mem[i]  = random_word();
            c_init[i] = random_word();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        if (busy_o || done_o || b_credit_o || a_rd_en_o || c_rd_en_o || c_wr_en_o) begin
            ctrl_errors++;
            $display("DUT outputs were not idle at the end of reset");
        end
        reset_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("Error counts: %0d value, %0d control", value_errors, ctrl_errors);
        if (value_errors + ctrl_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the DUT did not finish all rows in time");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
source/pw_pkg.sv
source/pw_ctrl_fsm.sv
source/pw_word_counter.sv
source/pw_b_credit_fifo.sv
source/pw_mod_lane.sv
source/pw_top.sv
tb/pw_asserts.sv
tb/pw_tb.sv

// File: run.sh
#!/bin/sh
# Compile the pointwise engine with its testbench and run it under Verilator

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module pw_tb -o pw_sim \
    > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/pw_sim > sim.log 2>&1
cat sim.log

grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation stopped early"; exit 1; }
echo "Simulation passed"
